//--- logic/cpu_pkg.sv
package cpu_pkg;

	// basic data and address word
	typedef logic [15:0] word_t;

	// opcodes live in instruction bits 15:12
	// 1, 7 and 13 are reserved and run as no-ops
	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd2,
		OP_XOR = 4'd3,
		OP_SLL = 4'd4,
		OP_SRA = 4'd5,
		OP_ROR = 4'd6,
		OP_LW  = 4'd8,
		OP_SW  = 4'd9,
		OP_LLB = 4'd10,
		OP_LHB = 4'd11,
		OP_B   = 4'd12,
		OP_PCS = 4'd14,
		OP_HLT = 4'd15
	} opcode_e;

	// branch condition codes, instruction bits 11:9
	typedef enum logic [2:0] {
		COND_NE     = 3'd0,
		COND_EQ     = 3'd1,
		COND_GT     = 3'd2,
		COND_LT     = 3'd3,
		COND_GE     = 3'd4,
		COND_LE     = 3'd5,
		COND_OV     = 3'd6,
		COND_ALWAYS = 3'd7
	} cond_e;

	// alu operations
	// ALU_ADDR is zero so an all-zero control word writes no flags
	typedef enum logic [2:0] {
		ALU_ADDR = 3'd0,
		ALU_ADD  = 3'd1,
		ALU_SUB  = 3'd2,
		ALU_XOR  = 3'd3,
		ALU_SLL  = 3'd4,
		ALU_SRA  = 3'd5,
		ALU_ROR  = 3'd6
	} alu_op_e;

	// register format, rt doubles as imm4
	typedef struct packed {
		opcode_e    opcode;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
	} instr_t;

	// flag bit order is also the order of the flag write enables
	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

	typedef struct packed {
		logic    reg_write;
		logic    mem_write;
		logic    mem_to_reg;
		logic    alu_src_imm;
		logic    alu_result;
		logic    load_low;
		logic    load_high;
		logic    pcs;
		logic    branch;
		logic    halt;
		alu_op_e alu_op;
	} ctrl_t;

	// one record per committed instruction
	typedef struct packed {
		logic       valid;
		word_t      pc;
		logic       halt;
		logic       reg_we;
		logic [3:0] dst;
		word_t      reg_data;
		logic       mem_we;
		word_t      mem_addr;
		word_t      mem_data;
	} retire_t;

	// branch condition overlays bits 11:9
	function automatic cond_e instr_cond(instr_t i);
		return cond_e'(i.rd[3:1]);
	endfunction

	// branch offset in halfwords, bits 8:0
	function automatic logic [8:0] instr_imm9(instr_t i);
		return {i.rd[0], i.rs, i.rt};
	endfunction

	// LLB/LHB byte, bits 7:0
	function automatic logic [7:0] instr_imm8(instr_t i);
		return {i.rs, i.rt};
	endfunction

endpackage

//--- logic/pc_control.sv
`timescale 1ns/10ps

module pc_control
	import cpu_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       run,
	input  instr_t     instr,
	input  ctrl_t      ctrl,
	input  flags_t     flags_new,
	input  logic [2:0] flag_we,
	output word_t      pc,
	output word_t      pc_plus2,
	output logic       hlt
);

	flags_t     flags;
	logic [8:0] imm9;
	word_t      branch_off;
	word_t      next_pc;
	logic       cond_met;

	// halt only counts while the core is running
	assign hlt = ctrl.halt & run;

	assign pc_plus2 = pc + 16'd2;

	// sign extend and scale to bytes
	assign imm9       = instr_imm9(instr);
	assign branch_off = {{6{imm9[8]}}, imm9, 1'b0};

	// condition is judged on the flags from earlier instructions
	always_comb begin
		case (instr_cond(instr))
			COND_NE:     cond_met = ~flags.z;
			COND_EQ:     cond_met = flags.z;
			COND_GT:     cond_met = ~flags.z & ~flags.n;
			COND_LT:     cond_met = flags.n;
			COND_GE:     cond_met = ~flags.n;
			COND_LE:     cond_met = flags.n | flags.z;
			COND_OV:     cond_met = flags.v;
			default:     cond_met = 1'b1;
		endcase
	end

	// halt freezes the pc on the HLT word
	always_comb begin
		if (hlt)
			next_pc = pc;
		else if (ctrl.branch && cond_met)
			next_pc = pc_plus2 + branch_off;
		else
			next_pc = pc_plus2;
	end

	// held at zero while stopped, so every run starts at 0
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pc <= '0;
		else if (!run)
			pc <= '0;
		else
			pc <= next_pc;
	end

	// per-flag update, each bit has its own enable
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags <= '0;
		end else if (!run) begin
			flags <= '0;
		end else if (!hlt) begin
			if (flag_we[2])
				flags.z <= flags_new.z;
			if (flag_we[1])
				flags.v <= flags_new.v;
			if (flag_we[0])
				flags.n <= flags_new.n;
		end
	end

	// halfword aligned fetch across all branches and restarts
	pc_even: assert property (@(posedge clk) disable iff (!arst_n) pc[0] == 1'b0);

endmodule

//--- logic/control_unit.sv
`timescale 1ns/10ps

module control_unit
	import cpu_pkg::*;
(
	input  opcode_e opcode,
	output ctrl_t   ctrl
);

	always_comb begin
		// reserved opcodes fall through with everything off
		ctrl = '0;
		case (opcode)
			OP_ADD, OP_SUB, OP_XOR: begin
				ctrl.reg_write  = 1'b1;
				ctrl.alu_result = 1'b1;
				ctrl.alu_op     = (opcode == OP_ADD) ? ALU_ADD :
				                  (opcode == OP_SUB) ? ALU_SUB : ALU_XOR;
			end
			// shift amount comes from imm4
			OP_SLL, OP_SRA, OP_ROR: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_result  = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op      = (opcode == OP_SLL) ? ALU_SLL :
				                   (opcode == OP_SRA) ? ALU_SRA : ALU_ROR;
			end
			OP_LW: begin
				ctrl.reg_write   = 1'b1;
				ctrl.mem_to_reg  = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op      = ALU_ADDR;
			end
			OP_SW: begin
				ctrl.mem_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op      = ALU_ADDR;
			end
			OP_LLB: begin
				ctrl.reg_write = 1'b1;
				ctrl.load_low  = 1'b1;
			end
			OP_LHB: begin
				ctrl.reg_write = 1'b1;
				ctrl.load_high = 1'b1;
			end
			OP_B:   ctrl.branch = 1'b1;
			OP_PCS: begin
				ctrl.reg_write = 1'b1;
				ctrl.pcs       = 1'b1;
			end
			OP_HLT: ctrl.halt = 1'b1;
			default: ctrl = '0;
		endcase
	end

endmodule

//--- logic/register_file.sv
`timescale 1ns/10ps

module register_file
	import cpu_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic [3:0] rs,
	input  logic [3:0] rt,
	input  logic [3:0] rd,
	input  logic       we,
	input  word_t      wdata,
	output word_t      rs_data,
	output word_t      rt_data,
	output word_t      rd_data
);

	// r0 has no storage at all
	word_t regs [1:15];

	// reads are combinational, r0 reads zero
	assign rs_data = (rs == '0) ? '0 : regs[rs];
	assign rt_data = (rt == '0) ? '0 : regs[rt];
	// rd port is for the LLB/LHB merge and store data
	assign rd_data = (rd == '0) ? '0 : regs[rd];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 16; i++)
				regs[i] <= '0;
		end else if (we && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	// the top already strips r0 destinations from the write enable
	no_r0_write: assert property (@(posedge clk) disable iff (!arst_n) we |-> rd != '0);

endmodule

//--- logic/alu.sv
`timescale 1ns/10ps

module alu
	import cpu_pkg::*;
(
	input  word_t      a,
	input  word_t      b,
	input  alu_op_e    alu_op,
	output word_t      result,
	output flags_t     flags,
	output logic [2:0] flag_we
);

	word_t       sum;
	word_t       diff;
	logic        sum_ovf;
	logic        diff_ovf;
	logic [3:0]  sh;
	logic [31:0] rot;

	assign sum  = a + b;
	assign diff = a - b;

	// signed overflow when operand signs predict a different result sign
	assign sum_ovf  = (a[15] == b[15]) && (sum[15] != a[15]);
	assign diff_ovf = (a[15] != b[15]) && (diff[15] != a[15]);

	// shifts use only the low nibble
	assign sh  = b[3:0];
	assign rot = {a, a} >> sh;

	always_comb begin
		case (alu_op)
			// clamp to 7FFF or 8000 following the sign of a
			ALU_ADD: result = sum_ovf ? (a[15] ? 16'h8000 : 16'h7fff) : sum;
			ALU_SUB: result = diff_ovf ? (a[15] ? 16'h8000 : 16'h7fff) : diff;
			ALU_XOR: result = a ^ b;
			ALU_SLL: result = a << sh;
			ALU_SRA: result = word_t'($signed(a) >>> sh);
			ALU_ROR: result = rot[15:0];
			// LW/SW address, offset counts halfwords
			default: result = a + {b[14:0], 1'b0};
		endcase
	end

	assign flags.z = (result == '0);
	assign flags.v = (alu_op == ALU_ADD) ? sum_ovf : diff_ovf;
	assign flags.n = result[15];

	// enables follow the operation, address adds leave flags alone
	always_comb begin
		case (alu_op)
			ALU_ADD, ALU_SUB: flag_we = 3'b111;
			ALU_XOR, ALU_SLL, ALU_SRA, ALU_ROR: flag_we = 3'b100;
			default: flag_we = 3'b000;
		endcase
	end

endmodule

//--- logic/memory_array.sv
`timescale 1ns/10ps

module memory_array #(
	parameter int  WORDS     = 256,
	parameter type word_type = logic [15:0]
) (
	input  logic                     clk,
	input  logic                     we,
	input  logic [$clog2(WORDS)-1:0] addr,
	input  word_type                 wdata,
	output word_type                 rdata
);

	// contents come from program load or stores, no reset
	word_type mem [WORDS];

	// asynchronous read for single cycle fetch and load
	assign rdata = mem[addr];

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
	end

	// index must land inside the array when WORDS is not a power of two
	write_in_range: assert property (@(posedge clk) we |-> addr < WORDS);

endmodule

//--- logic/cpu.sv
`timescale 1ns/10ps

module cpu
	import cpu_pkg::*;
#(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       run,
	input  logic       load_en,
	input  logic [7:0] load_addr,
	input  instr_t     load_data,
	output logic       hlt,
	output word_t      pc,
	output retire_t    retire
);

	localparam int IMEM_AW = $clog2(IMEM_WORDS);
	localparam int DMEM_AW = $clog2(DMEM_WORDS);

	instr_t             instr;
	ctrl_t              ctrl;
	word_t              pc_plus2;
	word_t              rs_data;
	word_t              rt_data;
	word_t              rd_data;
	word_t              imm_ext;
	word_t              alu_b;
	word_t              alu_out;
	flags_t             alu_flags;
	logic [2:0]         alu_flag_we;
	word_t              dmem_rdata;
	word_t              wdata;
	logic [7:0]         imm8;
	logic               commit;
	logic               reg_we;
	logic               dmem_we;
	logic               imem_we;
	logic [IMEM_AW-1:0] imem_addr;
	logic               halted;

	// an instruction commits on every running, non-halted cycle
	assign commit = run & ~hlt;

	// program load only while stopped, fetch from pc otherwise
	assign imem_we   = load_en & ~run;
	assign imem_addr = run ? pc[IMEM_AW:1] : load_addr[IMEM_AW-1:0];

	pc_control u_pc_control (
		.clk       (clk),
		.arst_n    (arst_n),
		.run       (run),
		.instr     (instr),
		.ctrl      (ctrl),
		.flags_new (alu_flags),
		.flag_we   (alu_flag_we),
		.pc        (pc),
		.pc_plus2  (pc_plus2),
		.hlt       (hlt)
	);

	memory_array #(
		.WORDS     (IMEM_WORDS),
		.word_type (instr_t)
	) u_imem (
		.clk   (clk),
		.we    (imem_we),
		.addr  (imem_addr),
		.wdata (load_data),
		.rdata (instr)
	);

	control_unit u_control_unit (
		.opcode (instr.opcode),
		.ctrl   (ctrl)
	);

	// r0 destinations never reach the register file
	assign reg_we = ctrl.reg_write & commit & (instr.rd != '0);

	register_file u_register_file (
		.clk     (clk),
		.arst_n  (arst_n),
		.rs      (instr.rs),
		.rt      (instr.rt),
		.rd      (instr.rd),
		.we      (reg_we),
		.wdata   (wdata),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.rd_data (rd_data)
	);

	// imm4 shares the rt field
	assign imm_ext = {{12{instr.rt[3]}}, instr.rt};
	assign alu_b   = ctrl.alu_src_imm ? imm_ext : rt_data;

	alu u_alu (
		.a       (rs_data),
		.b       (alu_b),
		.alu_op  (ctrl.alu_op),
		.result  (alu_out),
		.flags   (alu_flags),
		.flag_we (alu_flag_we)
	);

	assign dmem_we = ctrl.mem_write & commit;

	// byte address in, word index out
	// store data is the register named in bits 11:8
	memory_array #(
		.WORDS     (DMEM_WORDS),
		.word_type (word_t)
	) u_dmem (
		.clk   (clk),
		.we    (dmem_we),
		.addr  (alu_out[DMEM_AW:1]),
		.wdata (rd_data),
		.rdata (dmem_rdata)
	);

	assign imm8 = instr_imm8(instr);

	// write-back select
	always_comb begin
		if (ctrl.pcs)
			wdata = pc_plus2;
		else if (ctrl.mem_to_reg)
			wdata = dmem_rdata;
		else if (ctrl.load_low)
			wdata = (rd_data & 16'hff00) | {8'h00, imm8};
		else if (ctrl.load_high)
			wdata = (rd_data & 16'h00ff) | {imm8, 8'h00};
		else if (ctrl.alu_result)
			wdata = alu_out;
		else
			wdata = '0;
	end

	// set once the HLT word has been traced, cleared by stopping
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			halted <= 1'b0;
		else if (!run)
			halted <= 1'b0;
		else if (hlt)
			halted <= 1'b1;
	end

	// HLT itself gets one valid record with halt set, nothing after it
	assign retire.valid    = run & ~halted;
	assign retire.pc       = pc;
	assign retire.halt     = hlt;
	assign retire.reg_we   = reg_we;
	assign retire.dst      = instr.rd;
	assign retire.reg_data = wdata;
	assign retire.mem_we   = dmem_we;
	assign retire.mem_addr = alu_out;
	assign retire.mem_data = rd_data;

endmodule

//--- testbench/trace_checker.sv
`timescale 1ns/10ps

module trace_checker
	import cpu_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	input  retire_t retire,
	input  logic    hlt,
	input  word_t   pc,
	output int      tests_passed,
	output int      tests_failed
);

	// expected records of the running test, oldest first
	retire_t expected [$];
	retire_t want;
	string   test_name;
	logic    test_bad;
	logic    test_open;

	initial begin
		tests_passed = 0;
		tests_failed = 0;
		test_name    = "none";
		test_bad     = 1'b0;
		test_open    = 1'b0;
	end

	task automatic start_test(input string name);
		test_name = name;
		test_bad  = 1'b0;
		test_open = 1'b1;
		expected.delete();
	endtask

	task automatic expect_retire(input retire_t rec);
		expected.push_back(rec);
	endtask

	// one field of the current retire against its expected value
	task automatic check_field(input string field, input word_t exp_val, input word_t act_val);
		if (exp_val !== act_val) begin
			$display("MISMATCH test %s pc %h %s: expected %h actual %h",
				test_name, retire.pc, field, exp_val, act_val);
			test_bad = 1'b1;
		end
	endtask

	// trace is combinational, so take it at the commit edge
	always @(posedge clk) begin
		if (arst_n && retire.valid) begin
			if (!test_open) begin
				$display("retire at pc %h while no test was running", retire.pc);
				tests_failed++;
			end else if (expected.size() == 0) begin
				$display("test %s: retire at pc %h after the last expected record",
					test_name, retire.pc);
				test_bad = 1'b1;
			end else begin
				want = expected.pop_front();
				check_field("pc", want.pc, retire.pc);
				// the top's own pc port must track the traced pc
				check_field("pc_out", want.pc, pc);
				check_field("halt", 16'(want.halt), 16'(retire.halt));
				check_field("hlt", 16'(want.halt), 16'(hlt));
				check_field("reg_we", 16'(want.reg_we), 16'(retire.reg_we));
				check_field("mem_we", 16'(want.mem_we), 16'(retire.mem_we));
				// data fields only mean something when the write is on
				if (want.reg_we) begin
					check_field("dst", 16'(want.dst), 16'(retire.dst));
					check_field("reg_data", want.reg_data, retire.reg_data);
				end
				if (want.mem_we) begin
					check_field("mem_addr", want.mem_addr, retire.mem_addr);
					check_field("mem_data", want.mem_data, retire.mem_data);
				end
			end
		end
	end

	// leftover records mean the program stopped early
	task automatic end_test();
		if (expected.size() != 0) begin
			$display("test %s ended with %0d expected retires that never appeared",
				test_name, expected.size());
			test_bad = 1'b1;
		end
		if (test_bad) begin
			tests_failed++;
			$display("test %s failed", test_name);
		end else begin
			tests_passed++;
			$display("test %s passed", test_name);
		end
		test_open = 1'b0;
	endtask

endmodule

//--- testbench/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb
	import cpu_pkg::*;
();

	localparam string STIM_FILE = "testbench/cpu_stimulus.txt";

	logic       clk = 1'b0;
	logic       arst_n;
	logic       run;
	logic       load_en;
	logic [7:0] load_addr;
	instr_t     load_data;
	logic       hlt;
	word_t      pc;
	retire_t    retire;
	int         tests_passed;
	int         tests_failed;
	int         limit_cycles = 0;
	logic       file_error = 1'b0;

	// program and expected trace of the test being collected
	instr_t  prog_words [$];
	retire_t exp_records [$];
	string   cur_name;

	// 20 ns period
	always #10 clk = ~clk;

	cpu #(
		.IMEM_WORDS (256),
		.DMEM_WORDS (256)
	) DUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.run       (run),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.hlt       (hlt),
		.pc        (pc),
		.retire    (retire)
	);

	trace_checker u_trace_checker (
		.clk          (clk),
		.arst_n       (arst_n),
		.retire       (retire),
		.hlt          (hlt),
		.pc           (pc),
		.tests_passed (tests_passed),
		.tests_failed (tests_failed)
	);

	// program size sets the watchdog budget
	task automatic count_program_words(output int words);
		int    fd;
		int    n;
		string line;
		string tag;
		words = 0;
		fd = $fopen(STIM_FILE, "r");
		if (fd != 0) begin
			while ($fgets(line, fd) != 0) begin
				n = $sscanf(line, "%s", tag);
				if (n == 1 && tag == "P")
					words++;
			end
			$fclose(fd);
		end
	endtask

	// load while stopped, run to HLT, then stop and close the test
	task automatic run_test();
		int gap;
		gap = int'($urandom % 4) + 1;
		repeat (gap) @(negedge clk);
		for (int i = 0; i < prog_words.size(); i++) begin
			load_en   = 1'b1;
			load_addr = 8'(i);
			load_data = prog_words[i];
			@(negedge clk);
		end
		load_en = 1'b0;
		u_trace_checker.start_test(cur_name);
		foreach (exp_records[i])
			u_trace_checker.expect_retire(exp_records[i]);
		run = 1'b1;
		@(negedge clk);
		while (!hlt)
			@(negedge clk);
		// the HLT record reaches the checker on the next edge
		// then stay running a little so any retire after HLT shows up
		repeat (3) @(negedge clk);
		run = 1'b0;
		@(negedge clk);
		u_trace_checker.end_test();
	endtask

	initial begin
		int          fd;
		int          n;
		int          words;
		logic        have_test;
		string       line;
		string       tag;
		string       name;
		logic [15:0] p_word;
		logic [15:0] f_pc, f_rwe, f_dst, f_rdata;
		logic [15:0] f_mwe, f_maddr, f_mdata, f_halt;
		retire_t     rec;
		// one seed for the whole run
		void'($urandom(32'h4b00e3b7));
		arst_n    = 1'b0;
		run       = 1'b0;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		have_test = 1'b0;
		count_program_words(words);
		limit_cycles = words * 4 + 100;
		repeat (8) @(negedge clk);
		arst_n = 1'b1;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("could not open stimulus file %s", STIM_FILE);
			file_error = 1'b1;
		end else begin
			while ($fgets(line, fd) != 0) begin
				n = $sscanf(line, "%s", tag);
				// blank lines and # comments carry no record
				if (n == 1 && tag.getc(0) != 8'h23) begin
					if (tag == "T") begin
						if (have_test)
							run_test();
						n = $sscanf(line, "%s %s", tag, name);
						cur_name = name;
						prog_words.delete();
						exp_records.delete();
						have_test = 1'b1;
					end else if (tag == "P") begin
						n = $sscanf(line, "%s %h", tag, p_word);
						prog_words.push_back(instr_t'(p_word));
					end else if (tag == "E") begin
						n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", tag, f_pc, f_rwe,
							f_dst, f_rdata, f_mwe, f_maddr, f_mdata, f_halt);
						if (n != 9) begin
							$display("malformed expected record: %s", line);
							file_error = 1'b1;
						end
						rec          = '0;
						rec.valid    = 1'b1;
						rec.pc       = f_pc;
						rec.reg_we   = f_rwe[0];
						rec.dst      = f_dst[3:0];
						rec.reg_data = f_rdata;
						rec.mem_we   = f_mwe[0];
						rec.mem_addr = f_maddr;
						rec.mem_data = f_mdata;
						rec.halt     = f_halt[0];
						exp_records.push_back(rec);
					end else begin
						$display("unknown record type %s in stimulus file", tag);
						file_error = 1'b1;
					end
				end
			end
			$fclose(fd);
			if (have_test)
				run_test();
		end
		$display("tests passed %0d failed %0d", tests_passed, tests_failed);
		if (!file_error && tests_failed == 0 && tests_passed > 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// watchdog budget grows with the program sizes in the file
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", limit_cycles);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- testbench/cpu_stimulus.txt
# T name | P instruction word (hex)
# E pc reg_we dst reg_data mem_we mem_addr mem_data halt (all hex)
T alu
P A1FF
P B17F
P A201
P 0312
P B480
P 2542
P 0614
P 3761
P 4814
P 5943
P 6A21
P 6B18
P 0011
P 0C02
P 0D44
P 2E14
P F000
E 0000 1 1 00FF 0 0000 0000 0
E 0002 1 1 7FFF 0 0000 0000 0
E 0004 1 2 0001 0 0000 0000 0
E 0006 1 3 7FFF 0 0000 0000 0
E 0008 1 4 8000 0 0000 0000 0
E 000A 1 5 8000 0 0000 0000 0
E 000C 1 6 FFFF 0 0000 0000 0
E 000E 1 7 8000 0 0000 0000 0
E 0010 1 8 FFF0 0 0000 0000 0
E 0012 1 9 F000 0 0000 0000 0
E 0014 1 A 8000 0 0000 0000 0
E 0016 1 B FF7F 0 0000 0000 0
E 0018 0 0 0000 0 0000 0000 0
E 001A 1 C 0001 0 0000 0000 0
E 001C 1 D 8000 0 0000 0000 0
E 001E 1 E 7FFF 0 0000 0000 0
E 0020 0 0 0000 0 0000 0000 1
T imm
P A612
P B634
P B8AB
P E900
P EF00
P F000
E 0000 1 6 FF12 0 0000 0000 0
E 0002 1 6 3412 0 0000 0000 0
E 0004 1 8 ABF0 0 0000 0000 0
E 0006 1 9 0008 0 0000 0000 0
E 0008 1 F 000A 0 0000 0000 0
E 000A 0 0 0000 0 0000 0000 1
T mem
P A340
P B300
P 9632
P 983F
P 8A32
P 8B3F
P 9137
P 8C37
P F000
E 0000 1 3 7F40 0 0000 0000 0
E 0002 1 3 0040 0 0000 0000 0
E 0004 0 0 0000 1 0044 3412 0
E 0006 0 0 0000 1 003E ABF0 0
E 0008 1 A 3412 0 0000 0000 0
E 000A 1 B ABF0 0 0000 0000 0
E 000C 0 0 0000 1 004E 7FFF 0
E 000E 1 C 7FFF 0 0000 0000 0
E 0010 0 0 0000 0 0000 0000 1
T branch
P 0522
P C001
P F000
P C201
P C401
P F000
P C601
P C801
P F000
P CA01
P CC01
P 3555
P C201
P F000
P C001
P CA01
P F000
P C401
P 2542
P 3622
P CC01
P F000
P C601
P F000
P C801
P CE01
P F000
P CFFE
E 0000 1 5 0002 0 0000 0000 0
E 0002 0 0 0000 0 0000 0000 0
E 0006 0 0 0000 0 0000 0000 0
E 0008 0 0 0000 0 0000 0000 0
E 000C 0 0 0000 0 0000 0000 0
E 000E 0 0 0000 0 0000 0000 0
E 0012 0 0 0000 0 0000 0000 0
E 0014 0 0 0000 0 0000 0000 0
E 0016 1 5 0000 0 0000 0000 0
E 0018 0 0 0000 0 0000 0000 0
E 001C 0 0 0000 0 0000 0000 0
E 001E 0 0 0000 0 0000 0000 0
E 0022 0 0 0000 0 0000 0000 0
E 0024 1 5 8000 0 0000 0000 0
E 0026 1 6 0000 0 0000 0000 0
E 0028 0 0 0000 0 0000 0000 0
E 002C 0 0 0000 0 0000 0000 0
E 0030 0 0 0000 0 0000 0000 0
E 0032 0 0 0000 0 0000 0000 0
E 0036 0 0 0000 0 0000 0000 0
E 0034 0 0 0000 0 0000 0000 1
T halt
P C201
P CC01
P 1123
P D123
P 0722
P F000
P 0811
E 0000 0 0 0000 0 0000 0000 0
E 0002 0 0 0000 0 0000 0000 0
E 0004 0 0 0000 0 0000 0000 0
E 0006 0 0 0000 0 0000 0000 0
E 0008 1 7 0002 0 0000 0000 0
E 000A 0 0 0000 0 0000 0000 1

//--- cpu.f
logic/cpu_pkg.sv
logic/pc_control.sv
logic/control_unit.sv
logic/register_file.sv
logic/alu.sv
logic/memory_array.sv
logic/cpu.sv
testbench/trace_checker.sv
testbench/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := cpu_tb
FILELIST  := cpu.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
